// File: arcade_shell.f
logic/shell_pkg.sv
logic/rom_write_if.sv
logic/boot_loader.sv
logic/rom_store.sv
logic/input_mapper.sv
logic/video_out.sv
logic/audio_dac.sv
logic/arcade_shell.sv
dv/shell_checker.sv
dv/arcade_shell_tb.sv

// File: dv/arcade_shell_tb.sv
module arcade_shell_tb
	import shell_pkg::*;
();

	logic                    sys_clk;
	logic                    rst;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]              ioctl_dout;
	logic                    reset_request;
	logic                    key_strobe;
	logic                    key_pressed;
	logic [7:0]              key_code;
	logic [7:0]              joystick_0;
	logic [7:0]              joystick_1;
	logic [ROM_ADDR_W-1:0]   rom_addr;
	logic [2:0]              red;
	logic [2:0]              green;
	logic [1:0]              blue;
	logic                    blankn;
	logic                    hsync;
	logic                    vsync;
	logic                    csync;
	logic                    tv15khz;
	logic [AUDIO_W-1:0]      audio_in;
	logic                    led;
	logic                    core_reset;
	logic [7:0]              rom_data;
	logic                    ctl_up;
	logic                    ctl_down;
	logic                    ctl_left;
	logic                    ctl_right;
	logic                    ctl_fire1;
	logic                    ctl_fire2;
	logic                    ctl_coin;
	logic                    ctl_start1;
	logic                    ctl_start2;
	logic [5:0]              vga_r;
	logic [5:0]              vga_g;
	logic [5:0]              vga_b;
	logic                    vga_hs;
	logic                    vga_vs;
	logic                    audio_l;
	logic                    audio_r;

	// expected values and check enables for the checker
	logic                  rom_check;
	logic [ROM_ADDR_W-1:0] exp_addr;
	logic [7:0]            exp_rom_data;
	logic                  reset_check;
	logic                  exp_core_reset;
	logic                  ctl_check;
	player_controls_t      exp_controls;
	logic                  video_check;
	logic [19:0]           exp_video;
	logic                  ones_clear;
	logic                  ones_count;
	logic                  ones_check;
	int                    exp_ones;
	int                    rom_errors;
	int                    reset_errors;
	int                    ctl_errors;
	int                    video_errors;
	int                    audio_errors;
	int                    timeouts;
	int                    total;

	logic [7:0]       rom_model [0:2**ROM_ADDR_W-1];
	logic             rom_written [0:2**ROM_ADDR_W-1];
	player_controls_t key_model;
	player_controls_t dut_controls;
	logic [15:0]      lfsr;
	logic [AUDIO_W-1:0] level;

	assign dut_controls = {ctl_up, ctl_down, ctl_left, ctl_right, ctl_fire1, ctl_fire2,
		ctl_coin, ctl_start1, ctl_start2};

	arcade_shell arcade_shell_inst (.*);

	shell_checker shell_checker_inst (
		.sys_clk        (sys_clk),
		.ioctl_download (ioctl_download),
		.led            (led),
		.core_reset     (core_reset),
		.rom_data       (rom_data),
		.controls       (dut_controls),
		.vga_r          (vga_r),
		.vga_g          (vga_g),
		.vga_b          (vga_b),
		.vga_hs         (vga_hs),
		.vga_vs         (vga_vs),
		.audio_l        (audio_l),
		.audio_r        (audio_r),
		.rom_check      (rom_check),
		.exp_addr       (exp_addr),
		.exp_rom_data   (exp_rom_data),
		.reset_check    (reset_check),
		.exp_core_reset (exp_core_reset),
		.ctl_check      (ctl_check),
		.exp_controls   (exp_controls),
		.video_check    (video_check),
		.exp_video      (exp_video),
		.ones_clear     (ones_clear),
		.ones_count     (ones_count),
		.ones_check     (ones_check),
		.exp_ones       (exp_ones),
		.rom_errors     (rom_errors),
		.reset_errors   (reset_errors),
		.ctl_errors     (ctl_errors),
		.video_errors   (video_errors),
		.audio_errors   (audio_errors)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic player_controls_t key_update(input player_controls_t keys,
			input logic [7:0] code, input logic pressed);
		player_controls_t upd;
		upd = keys;
		case (code)
			KEY_UP:     upd.up     = pressed;
			KEY_DOWN:   upd.down   = pressed;
			KEY_LEFT:   upd.left   = pressed;
			KEY_RIGHT:  upd.right  = pressed;
			KEY_COIN:   upd.coin   = pressed;
			KEY_START1: upd.start1 = pressed;
			KEY_START2: upd.start2 = pressed;
			KEY_FIRE1:  upd.fire1  = pressed;
			KEY_FIRE2:  upd.fire2  = pressed;
			default: ;
		endcase
		return upd;
	endfunction

	function automatic player_controls_t control_rule(input player_controls_t keys,
			input logic [7:0] j0, input logic [7:0] j1);
		player_controls_t c;
		c       = keys; // coin and starts pass as is
		c.up    = keys.up | j0[JOY_UP] | j1[JOY_UP];
		c.down  = keys.down | j0[JOY_DOWN] | j1[JOY_DOWN];
		c.left  = keys.left | j0[JOY_LEFT] | j1[JOY_LEFT];
		c.right = keys.right | j0[JOY_RIGHT] | j1[JOY_RIGHT];
		c.fire1 = keys.fire1 | j0[JOY_FIRE1] | j1[JOY_FIRE1];
		c.fire2 = keys.fire2 | j0[JOY_FIRE2] | j1[JOY_FIRE2];
		return c;
	endfunction

	function automatic logic [19:0] video_rule(input logic [2:0] r, input logic [2:0] g,
			input logic [1:0] b, input logic blank_n, input logic hs, input logic vs,
			input logic cs, input logic tv);
		logic [2:0] r3;
		logic [2:0] g3;
		logic [2:0] b3;
		r3 = blank_n ? r : 3'd0;
		g3 = blank_n ? g : 3'd0;
		b3 = blank_n ? {b, b[1]} : 3'd0;
		return {r3, r3, g3, g3, b3, b3, tv ? cs : hs, tv ? 1'b1 : vs};
	endfunction

	// carries over n cycles equal the whole wraps of n * sample
	function automatic int sd_ones(input logic [AUDIO_W-1:0] sample, input longint cycles);
		return int'((cycles * longint'(sample)) >> AUDIO_W);
	endfunction

	task automatic next_cycle();
		@(posedge sys_clk);
		#10;
	endtask

	task automatic wait_core_reset(input logic target);
		int n;
		n = 0;
		while (core_reset !== target && n < 100) begin
			next_cycle();
			n++;
		end
		if (core_reset !== target) begin
			$display("timeout: core_reset did not go to %0b within 100 cycles", target);
			timeouts++;
		end
	endtask

	task automatic load_rom();
		logic [ROM_ADDR_W-1:0] a;
		logic [7:0]            d;
		ioctl_download = 1'b1;
		next_cycle();
		for (int i = 0; i < 256; i++) begin
			a              = ROM_ADDR_W'(rand_bits(ROM_ADDR_W));
			d              = 8'(rand_bits(8));
			ioctl_addr     = IOCTL_ADDR_W'(a);
			ioctl_dout     = d;
			ioctl_wr       = 1'b1;
			rom_model[a]   = d;
			rom_written[a] = 1'b1;
			next_cycle();
			ioctl_wr = 1'b0; // gap between bytes
			next_cycle();
		end
		ioctl_download = 1'b0;
		reset_check    = 1'b0;
		wait_core_reset(1'b0);
	endtask

	task automatic read_rom();
		logic [ROM_ADDR_W-1:0] prev;
		prev = '0;
		for (int a = 0; a <= 2**ROM_ADDR_W; a++) begin
			rom_addr     = ROM_ADDR_W'(a);
			rom_check    = (a > 0) && rom_written[prev];
			exp_addr     = prev;
			exp_rom_data = rom_model[prev];
			prev         = ROM_ADDR_W'(a);
			next_cycle();
		end
		rom_check = 1'b0;
	endtask

	task automatic request_reset();
		reset_request  = 1'b1;
		reset_check    = 1'b1;
		exp_core_reset = 1'b0; // request not sampled yet
		next_cycle();
		exp_core_reset = 1'b1;
		repeat (4) next_cycle();
		reset_request = 1'b0;
		reset_check   = 1'b0;
		wait_core_reset(1'b0);
	endtask

	task automatic key_test();
		logic [7:0] codes [0:8];
		logic [3:0] pick;
		codes     = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_COIN, KEY_START1,
			KEY_START2, KEY_FIRE1, KEY_FIRE2};
		key_model = '0;
		ctl_check = 1'b1;
		for (int i = 0; i < 400; i++) begin
			pick         = 4'(rand_bits(4));
			key_strobe   = (rand_bits(2) != 0);
			key_code     = (pick < 9) ? codes[pick] : 8'(rand_bits(8));
			key_pressed  = 1'(rand_bits(1));
			joystick_0   = 8'(rand_bits(8) & rand_bits(8)); // sparse bits
			joystick_1   = 8'(rand_bits(8) & rand_bits(8));
			exp_controls = control_rule(key_model, joystick_0, joystick_1);
			if (key_strobe)
				key_model = key_update(key_model, key_code, key_pressed);
			next_cycle();
		end
		key_strobe = 1'b0;
		ctl_check  = 1'b0;
	endtask

	task automatic video_test(input logic mode);
		tv15khz = mode;
		for (int i = 0; i < 200; i++) begin
			exp_video   = video_rule(red, green, blue, blankn, hsync, vsync, csync, tv15khz);
			video_check = (i > 0); // first cycle still sees the old mode
			red         = 3'(rand_bits(3));
			green       = 3'(rand_bits(3));
			blue        = 2'(rand_bits(2));
			blankn      = (rand_bits(2) != 0);
			hsync       = 1'(rand_bits(1));
			vsync       = 1'(rand_bits(1));
			csync       = 1'(rand_bits(1));
			next_cycle();
		end
		video_check = 1'b0;
	endtask

	task automatic audio_test(input logic [AUDIO_W-1:0] sample);
		rst        = 1'b1;
		audio_in   = sample;
		ones_clear = 1'b1;
		next_cycle();
		rst        = 1'b0;
		ones_clear = 1'b0;
		next_cycle();
		ones_count = 1'b1; // first accumulator step is visible now
		repeat (2**AUDIO_W) next_cycle();
		ones_count = 1'b0;
		exp_ones   = sd_ones(sample, 2**AUDIO_W);
		ones_check = 1'b1;
		next_cycle();
		ones_check = 1'b0;
	endtask

	initial begin
		lfsr           = 16'd95;
		timeouts       = 0;
		rst            = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		reset_request  = 1'b0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		rom_addr       = '0;
		red            = '0;
		green          = '0;
		blue           = '0;
		blankn         = 1'b0;
		hsync          = 1'b0;
		vsync          = 1'b0;
		csync          = 1'b0;
		tv15khz        = 1'b0;
		audio_in       = '0;
		rom_check      = 1'b0;
		exp_addr       = '0;
		exp_rom_data   = '0;
		reset_check    = 1'b0;
		exp_core_reset = 1'b1;
		ctl_check      = 1'b0;
		exp_controls   = '0;
		video_check    = 1'b0;
		exp_video      = '0;
		ones_clear     = 1'b0;
		ones_count     = 1'b0;
		ones_check     = 1'b0;
		exp_ones       = 0;
		for (int i = 0; i < 2**ROM_ADDR_W; i++)
			rom_written[i] = 1'b0;
		repeat (10) @(posedge sys_clk);
		#10;
		rst         = 1'b0;
		reset_check = 1'b1; // held until the rom is loaded
		load_rom();
		read_rom();
		request_reset();
		key_test();
		video_test(1'b0);
		video_test(1'b1);
		for (int k = 0; k < 4; k++) begin
			level = (k == 3) ? '1 : AUDIO_W'(rand_bits(AUDIO_W));
			audio_test(level);
		end
		next_cycle();
		total = rom_errors + reset_errors + ctl_errors + video_errors + audio_errors + timeouts;
		$display("errors: rom %0d, reset %0d, controls %0d, video %0d, audio %0d, timeouts %0d",
			rom_errors, reset_errors, ctl_errors, video_errors, audio_errors, timeouts);
		if (total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: dv/shell_checker.sv
module shell_checker
	import shell_pkg::*;
(
	input  logic                  sys_clk,
	input  logic                  ioctl_download,
	input  logic                  led,
	input  logic                  core_reset,
	input  logic [7:0]            rom_data,
	input  player_controls_t      controls,
	input  logic [5:0]            vga_r,
	input  logic [5:0]            vga_g,
	input  logic [5:0]            vga_b,
	input  logic                  vga_hs,
	input  logic                  vga_vs,
	input  logic                  audio_l,
	input  logic                  audio_r,
	input  logic                  rom_check,
	input  logic [ROM_ADDR_W-1:0] exp_addr,
	input  logic [7:0]            exp_rom_data,
	input  logic                  reset_check,
	input  logic                  exp_core_reset,
	input  logic                  ctl_check,
	input  player_controls_t      exp_controls,
	input  logic                  video_check,
	input  logic [19:0]           exp_video, // {r, g, b, hs, vs}
	input  logic                  ones_clear,
	input  logic                  ones_count,
	input  logic                  ones_check,
	input  int                    exp_ones,
	output int                    rom_errors,
	output int                    reset_errors,
	output int                    ctl_errors,
	output int                    video_errors,
	output int                    audio_errors
);

	int   ones;
	logic led_exp;

	assign led_exp = ~ioctl_download; // led lit while no download

	task automatic show_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAILED %s: got %0h expected %0h", name, got, exp);
	endtask

	initial begin
		rom_errors   = 0;
		reset_errors = 0;
		ctl_errors   = 0;
		video_errors = 0;
		audio_errors = 0;
		ones         = 0;
	end

	// mid-cycle sampling, inputs settle after the rising edge
	always @(negedge sys_clk) begin
		if (led !== led_exp) begin
			show_mismatch("led", led, led_exp);
			reset_errors++;
		end
		if (reset_check && core_reset !== exp_core_reset) begin
			show_mismatch("core_reset", core_reset, exp_core_reset);
			reset_errors++;
		end
		if (rom_check && rom_data !== exp_rom_data) begin
			$display("FAILED rom_data at address %h: got %h expected %h",
				exp_addr, rom_data, exp_rom_data);
			rom_errors++;
		end
		if (ctl_check && controls !== exp_controls) begin
			show_mismatch("ctl_up..ctl_start2", controls, exp_controls);
			ctl_errors++;
		end
		if (video_check) begin
			if (vga_r !== exp_video[19:14]) begin
				show_mismatch("vga_r", vga_r, exp_video[19:14]);
				video_errors++;
			end
			if (vga_g !== exp_video[13:8]) begin
				show_mismatch("vga_g", vga_g, exp_video[13:8]);
				video_errors++;
			end
			if (vga_b !== exp_video[7:2]) begin
				show_mismatch("vga_b", vga_b, exp_video[7:2]);
				video_errors++;
			end
			if (vga_hs !== exp_video[1]) begin
				show_mismatch("vga_hs", vga_hs, exp_video[1]);
				video_errors++;
			end
			if (vga_vs !== exp_video[0]) begin
				show_mismatch("vga_vs", vga_vs, exp_video[0]);
				video_errors++;
			end
		end
		if (audio_r !== audio_l) begin
			show_mismatch("audio_r", audio_r, audio_l);
			audio_errors++;
		end
		if (ones_clear)
			ones = 0;
		else if (ones_count)
			ones = ones + audio_l;
		if (ones_check && ones != exp_ones) begin
			show_mismatch("audio_l ones count", ones, exp_ones);
			audio_errors++;
		end
	end

endmodule

// File: logic/arcade_shell.sv
module arcade_shell
	import shell_pkg::*;
(
	input  logic                    sys_clk,
	input  logic                    rst,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]              ioctl_dout,
	input  logic                    reset_request,
	input  logic                    key_strobe,
	input  logic                    key_pressed,
	input  logic [7:0]              key_code,
	input  logic [7:0]              joystick_0,
	input  logic [7:0]              joystick_1,
	input  logic [ROM_ADDR_W-1:0]   rom_addr,
	input  logic [2:0]              red,
	input  logic [2:0]              green,
	input  logic [1:0]              blue,
	input  logic                    blankn,
	input  logic                    hsync,
	input  logic                    vsync,
	input  logic                    csync,
	input  logic                    tv15khz,
	input  logic [AUDIO_W-1:0]      audio_in,
	output logic                    led,
	output logic                    core_reset,
	output logic [7:0]              rom_data,
	output logic                    ctl_up,
	output logic                    ctl_down,
	output logic                    ctl_left,
	output logic                    ctl_right,
	output logic                    ctl_fire1,
	output logic                    ctl_fire2,
	output logic                    ctl_coin,
	output logic                    ctl_start1,
	output logic                    ctl_start2,
	output logic [5:0]              vga_r,
	output logic [5:0]              vga_g,
	output logic [5:0]              vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs,
	output logic                    audio_l,
	output logic                    audio_r
);

	rom_write_if      rom_wr ();
	player_controls_t controls;

	assign led = ~ioctl_download; // lit while idle

	boot_loader boot_loader_inst (
		.sys_clk        (sys_clk),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_request  (reset_request),
		.wr             (rom_wr.writer),
		.rom_loaded     (),
		.core_reset     (core_reset)
	);

	rom_store rom_store_inst (
		.sys_clk  (sys_clk),
		.wr       (rom_wr.store),
		.rom_addr (rom_addr),
		.rom_data (rom_data)
	);

	input_mapper input_mapper_inst (
		.sys_clk     (sys_clk),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.controls    (controls)
	);

	assign ctl_up     = controls.up;
	assign ctl_down   = controls.down;
	assign ctl_left   = controls.left;
	assign ctl_right  = controls.right;
	assign ctl_fire1  = controls.fire1;
	assign ctl_fire2  = controls.fire2;
	assign ctl_coin   = controls.coin;
	assign ctl_start1 = controls.start1;
	assign ctl_start2 = controls.start2;

	video_out video_out_inst (
		.sys_clk (sys_clk),
		.rst     (rst),
		.red     (red),
		.green   (green),
		.blue    (blue),
		.blankn  (blankn),
		.hsync   (hsync),
		.vsync   (vsync),
		.csync   (csync),
		.tv15khz (tv15khz),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	audio_dac audio_dac_inst (
		.sys_clk (sys_clk),
		.rst     (rst),
		.sample  (audio_in),
		.bit_out (audio_l)
	);

	assign audio_r = audio_l; // mono

endmodule

// File: logic/audio_dac.sv
module audio_dac
	import shell_pkg::*;
(
	input  logic               sys_clk,
	input  logic               rst,
	input  logic [AUDIO_W-1:0] sample,
	output logic               bit_out
);

	logic [AUDIO_W:0] acc;

	// first-order sigma-delta, carry out is the pulse stream
	always_ff @(posedge sys_clk) begin
		if (rst)
			acc <= '0;
		else
			acc <= {1'b0, acc[AUDIO_W-1:0]} + {1'b0, sample};
	end

	assign bit_out = acc[AUDIO_W];

endmodule

// File: logic/video_out.sv
module video_out (
	input  logic       sys_clk,
	input  logic       rst,
	input  logic [2:0] red,
	input  logic [2:0] green,
	input  logic [1:0] blue,
	input  logic       blankn,
	input  logic       hsync,
	input  logic       vsync,
	input  logic       csync,
	input  logic       tv15khz,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic [2:0] r_vis;
	logic [2:0] g_vis;
	logic [2:0] b_vis;

	assign r_vis = blankn ? red : 3'd0;
	assign g_vis = blankn ? green : 3'd0;
	assign b_vis = blankn ? {blue, blue[1]} : 3'd0; // widen blue to 3 bits

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			vga_r <= {r_vis, r_vis};
			vga_g <= {g_vis, g_vis};
			vga_b <= {b_vis, b_vis};
		end
	end

	// syncs track the inputs even in reset
	always_ff @(posedge sys_clk) begin
		vga_hs <= tv15khz ? csync : hsync;
		vga_vs <= tv15khz | vsync; // held high for 15 kHz
	end

endmodule

// File: logic/input_mapper.sv
module input_mapper
	import shell_pkg::*;
(
	input  logic             sys_clk,
	input  logic             rst,
	input  logic             key_strobe,
	input  logic             key_pressed,
	input  logic [7:0]       key_code,
	input  logic [7:0]       joystick_0,
	input  logic [7:0]       joystick_1,
	output player_controls_t controls
);

	player_controls_t keys;
	logic [7:0]       joy_any;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			keys <= '0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_UP:     keys.up     <= key_pressed;
				KEY_DOWN:   keys.down   <= key_pressed;
				KEY_LEFT:   keys.left   <= key_pressed;
				KEY_RIGHT:  keys.right  <= key_pressed;
				KEY_COIN:   keys.coin   <= key_pressed;
				KEY_START1: keys.start1 <= key_pressed;
				KEY_START2: keys.start2 <= key_pressed;
				KEY_FIRE1:  keys.fire1  <= key_pressed;
				KEY_FIRE2:  keys.fire2  <= key_pressed;
				default: ; // unknown codes ignored
			endcase
		end
	end

	// both players share one control set
	assign joy_any = joystick_0 | joystick_1;

	always_comb begin
		controls.up     = keys.up    | joy_any[JOY_UP];
		controls.down   = keys.down  | joy_any[JOY_DOWN];
		controls.left   = keys.left  | joy_any[JOY_LEFT];
		controls.right  = keys.right | joy_any[JOY_RIGHT];
		controls.fire1  = keys.fire1 | joy_any[JOY_FIRE1];
		controls.fire2  = keys.fire2 | joy_any[JOY_FIRE2];
		controls.coin   = keys.coin; // keyboard only
		controls.start1 = keys.start1;
		controls.start2 = keys.start2;
	end

endmodule

// File: logic/rom_store.sv
module rom_store
	import shell_pkg::*;
(
	input  logic                  sys_clk,
	rom_write_if.store            wr,
	input  logic [ROM_ADDR_W-1:0] rom_addr,
	output logic [7:0]            rom_data
);

	localparam int DEPTH = 2 ** ROM_WORD_ADDR_W;

	logic [15:0] mem [0:DEPTH-1];
	logic [15:0] rd_word;
	logic        rd_hi;

	always_ff @(posedge sys_clk) begin
		if (wr.valid) begin
			if (wr.byte_en[0])
				mem[wr.word_addr][7:0] <= wr.data[7:0];
			if (wr.byte_en[1])
				mem[wr.word_addr][15:8] <= wr.data[15:8];
		end
	end

	// old contents on a same-cycle collision
	always_ff @(posedge sys_clk) begin
		rd_word <= mem[rom_addr[ROM_ADDR_W-1:1]];
		rd_hi   <= rom_addr[0];
	end

	assign rom_data = rd_hi ? rd_word[15:8] : rd_word[7:0]; // odd address is high byte

endmodule

// File: logic/boot_loader.sv
module boot_loader
	import shell_pkg::*;
(
	input  logic                    sys_clk,
	input  logic                    rst,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]              ioctl_dout,
	input  logic                    reset_request,
	rom_write_if.writer             wr,
	output logic                    rom_loaded,
	output logic                    core_reset
);

	logic wr_d;
	logic download_d;
	logic wr_rise;
	logic download_fall;

	assign wr_rise       = ioctl_wr & ~wr_d;
	assign download_fall = download_d & ~ioctl_download;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			wr_d       <= 1'b0;
			download_d <= 1'b0;
			wr.valid   <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			wr_d       <= ioctl_wr;
			download_d <= ioctl_download;
			wr.valid   <= ioctl_download & wr_rise;
			if (download_fall)
				rom_loaded <= 1'b1; // sticky until rst
		end
	end

	// word payload, only meaningful with valid
	always_ff @(posedge sys_clk) begin
		if (ioctl_download & wr_rise) begin
			wr.word_addr <= ioctl_addr[ROM_WORD_ADDR_W:1];
			wr.byte_en   <= {ioctl_addr[0], ~ioctl_addr[0]};
			wr.data      <= {ioctl_dout, ioctl_dout};
		end
	end

	// holds the core until the rom is in
	always_ff @(posedge sys_clk) begin
		core_reset <= rst | reset_request | ~rom_loaded;
	end

endmodule

// File: logic/rom_write_if.sv
interface rom_write_if
	import shell_pkg::*;
();

	logic                       valid; // one-cycle strobe
	logic [ROM_WORD_ADDR_W-1:0] word_addr;
	logic [1:0]                 byte_en; // bit 1 is high byte
	logic [15:0]                data;

	modport writer (
		output valid, word_addr, byte_en, data
	);

	modport store (
		input valid, word_addr, byte_en, data
	);

endinterface

// File: logic/shell_pkg.sv
package shell_pkg;

	localparam int ROM_ADDR_W      = 15; // 32 KiB of rom
	localparam int ROM_WORD_ADDR_W = ROM_ADDR_W - 1;
	localparam int IOCTL_ADDR_W    = 25;
	localparam int AUDIO_W         = 16;

	// ps/2 set 2 scan codes
	localparam logic [7:0] KEY_UP     = 8'h75;
	localparam logic [7:0] KEY_DOWN   = 8'h72;
	localparam logic [7:0] KEY_LEFT   = 8'h6B;
	localparam logic [7:0] KEY_RIGHT  = 8'h74;
	localparam logic [7:0] KEY_COIN   = 8'h76; // esc
	localparam logic [7:0] KEY_START1 = 8'h05; // f1
	localparam logic [7:0] KEY_START2 = 8'h06; // f2
	localparam logic [7:0] KEY_FIRE1  = 8'h29; // space
	localparam logic [7:0] KEY_FIRE2  = 8'h11; // left alt

	// joystick word bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic coin;
		logic start1;
		logic start2;
	} player_controls_t;

endpackage
